/* i3c_pkg.sv */
/*
  I3C target shared types
  Bus request/response, address setup, decode result, payload and
  status types plus the protocol constants used across the target
*/
package i3c_pkg;

  // Seven-bit I3C address, R/W bit sits below it on the bus
  localparam int unsigned AddrWidth = 7;

  // 0x7E with write, the broadcast address byte
  localparam logic [7:0] BcastByte = 8'hFC;

  // Level driven on SDA to acknowledge
  localparam logic AckValue = 1'b0;

  typedef logic [7:0] byte_t;

  // One device's address setup
  // Dynamic address wins over static when both are valid
  typedef struct packed {
    logic [AddrWidth-1:0] sta_addr;
    logic                 sta_valid;
    logic [AddrWidth-1:0] dyn_addr;
    logic                 dyn_valid;
  } addr_cfg_t;

  // Decode result of the last captured address byte
  typedef struct packed {
    logic ours;
    logic virt;
    logic bcast;
    logic rnw;
  } match_t;

  // Request to the bus layer, exactly one request bit at a time
  // Bit transfers use tx_value[0] only
  typedef struct packed {
    logic  rx_byte;
    logic  rx_bit;
    logic  tx_byte;
    logic  tx_bit;
    byte_t tx_value;
  } bus_req_t;

  // Response from the bus layer
  // start covers both START and repeated START
  typedef struct packed {
    logic  done;
    byte_t data;
    logic  start;
    logic  stop;
  } bus_rsp_t;

  // TX queue entry for private reads
  typedef struct packed {
    byte_t data;
    logic  last;
  } tx_word_t;

  // Received private write byte
  typedef struct packed {
    byte_t data;
    logic  virt;
  } rx_word_t;

  // Broadcast command code
  typedef byte_t ccc_t;

  typedef struct packed {
    logic idle;
    logic transmitting;
    logic xfer_active;
    logic virt_sel;
  } status_t;

  // Step pulses from the sequencer to the RX result path
  typedef struct packed {
    logic byte_done;
    logic tbit_done;
    logic ccc_done;
    logic virt;
  } rx_cmd_t;

endpackage

/* i3c_out_stage.sv */
`timescale 1ns/1ps
/*
  One-entry valid/ready output stage
  Holds a single payload until the consumer takes it
*/
module i3c_out_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // Entry drained this cycle can be refilled at once
  assign full_o = valid_q && !ready_i;
  assign load   = push_i && !full_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* i3c_addr_decode.sv */
`timescale 1ns/1ps
/*
  I3C address decoder
  Holds the captured address byte and matches it against the own,
  virtual and broadcast addresses
*/
module i3c_addr_decode
  import i3c_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      capture_i,
  input  byte_t     byte_i,
  input  logic      clear_i,
  input  addr_cfg_t own_cfg_i,
  input  addr_cfg_t virt_cfg_i,
  output match_t    match_o
);

  logic [AddrWidth-1:0] addr_q;
  logic                 rnw_q;
  // Set once an address byte is held, so a cleared register never matches
  logic                 addr_vld_q;

  // {valid, address} of each device
  logic [AddrWidth:0]   own_eff;
  logic [AddrWidth:0]   virt_eff;

  // Dynamic address first, then static, else no address at all
  function automatic logic [AddrWidth:0] eff_addr(input addr_cfg_t cfg);
    logic [AddrWidth:0] res;
    if (cfg.dyn_valid) begin
      res = {1'b1, cfg.dyn_addr};
    end else if (cfg.sta_valid) begin
      res = {1'b1, cfg.sta_addr};
    end else begin
      res = '0;
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      rnw_q      <= 1'b0;
      addr_vld_q <= 1'b0;
    end else if (capture_i) begin
      // Bus order is address in the upper bits, R/W in bit 0
      addr_q     <= byte_i[7:1];
      rnw_q      <= byte_i[0];
      addr_vld_q <= 1'b1;
    end else if (clear_i) begin
      addr_q     <= '0;
      rnw_q      <= 1'b0;
      addr_vld_q <= 1'b0;
    end
  end

  assign own_eff  = eff_addr(own_cfg_i);
  assign virt_eff = eff_addr(virt_cfg_i);

  always_comb begin
    match_o.ours  = addr_vld_q && own_eff[AddrWidth] && (own_eff[AddrWidth-1:0] == addr_q);
    match_o.virt  = addr_vld_q && virt_eff[AddrWidth] && (virt_eff[AddrWidth-1:0] == addr_q);
    match_o.bcast = addr_vld_q && ({addr_q, rnw_q} == BcastByte);
    match_o.rnw   = rnw_q;
  end

endmodule

/* i3c_target_seq.sv */
`timescale 1ns/1ps
/*
  I3C target transfer sequencer
  Steps through address, ACK, private write, private read and broadcast
  CCC phases, issuing held bus requests, the ACK/NACK decision and TX pops
*/
module i3c_target_seq
  import i3c_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable_i,
  input  bus_rsp_t bus_rsp_i,
  output bus_req_t bus_req_o,
  input  match_t   match_i,
  output logic     capture_o,
  output logic     clear_o,
  input  logic     tx_valid_i,
  input  tx_word_t tx_word_i,
  output logic     tx_ready_o,
  output rx_cmd_t  rx_cmd_o,
  output logic     nack_o,
  output status_t  status_o
);

  typedef enum logic [3:0] {
    Idle,
    RxAddr,
    Check,
    AckAddr,
    RxCcc,
    WrData,
    WrTbit,
    RdData,
    RdTbit,
    Wait
  } state_e;

  state_e   state_q, state_d;
  logic     take_xfer;
  logic     nack_q;
  // Transfer selected the virtual device
  logic     virt_q;
  logic     xfer_q;
  // T-bit value for the byte in flight, 1 means more data follows
  logic     tbit_q;
  tx_word_t tx_q;

  // Broadcast always ACKed, reads only with a byte ready in the queue
  assign take_xfer = match_i.bcast |
                     ((match_i.ours | match_i.virt) & (~match_i.rnw | tx_valid_i));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Left only through the START and STOP overrides below
      Idle, Wait: ;
      RxAddr: begin
        if (bus_rsp_i.done) state_d = Check;
      end
      Check: begin
        state_d = take_xfer ? AckAddr : Wait;
      end
      AckAddr: begin
        if (bus_rsp_i.done) begin
          if (match_i.bcast) begin
            state_d = RxCcc;
          end else if (!match_i.rnw) begin
            state_d = WrData;
          end else if (tx_valid_i) begin
            state_d = RdData;
          end else begin
            state_d = Wait;
          end
        end
      end
      // Bytes after the command code are not taken
      RxCcc: begin
        if (bus_rsp_i.done) state_d = Wait;
      end
      WrData: begin
        if (bus_rsp_i.done) state_d = WrTbit;
      end
      WrTbit: begin
        if (bus_rsp_i.done) state_d = WrData;
      end
      RdData: begin
        if (bus_rsp_i.done) state_d = RdTbit;
      end
      RdTbit: begin
        if (bus_rsp_i.done) state_d = (tbit_q && tx_valid_i) ? RdData : Wait;
      end
      default: state_d = Idle;
    endcase

    // Repeated START restarts address reception
    if (enable_i && bus_rsp_i.start && (state_q != RxAddr)) state_d = RxAddr;
    // STOP wins over everything
    if (bus_rsp_i.stop) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      nack_q  <= 1'b0;
      virt_q  <= 1'b0;
      xfer_q  <= 1'b0;
      tbit_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // One pulse per refused transaction
      nack_q  <= (state_q == Check) && (state_d == Wait);
      if (state_q == Check) begin
        // Own address takes priority if both devices share it
        virt_q <= !match_i.bcast && match_i.virt && !match_i.ours;
        xfer_q <= take_xfer;
      end else if (state_q == Idle) begin
        virt_q <= 1'b0;
        xfer_q <= 1'b0;
      end
      // Empty queue after a non-last byte also ends the read
      if ((state_q == RdData) && bus_rsp_i.done) tbit_q <= !tx_q.last && tx_valid_i;
    end
  end

  // Pop one word on each entry into the read data state
  // Both entry paths already require a word in the queue
  assign tx_ready_o = (state_d == RdData) && (state_q != RdData);

  always_ff @(posedge clk_i) begin
    if (tx_ready_o) tx_q <= tx_word_i;
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      RxAddr, RxCcc, WrData: bus_req_o.rx_byte = 1'b1;
      WrTbit: bus_req_o.rx_bit = 1'b1;
      AckAddr: begin
        bus_req_o.tx_bit   = 1'b1;
        bus_req_o.tx_value = {7'h00, AckValue};
      end
      RdData: begin
        bus_req_o.tx_byte  = 1'b1;
        bus_req_o.tx_value = tx_q.data;
      end
      RdTbit: begin
        bus_req_o.tx_bit   = 1'b1;
        bus_req_o.tx_value = {7'h00, tbit_q};
      end
      default: ;
    endcase
  end

  // Decode reads the byte straight off the bus response
  assign capture_o = (state_q == RxAddr) && bus_rsp_i.done;
  assign clear_o   = (state_q == Idle);

  always_comb begin
    rx_cmd_o.byte_done = (state_q == WrData) && bus_rsp_i.done;
    rx_cmd_o.tbit_done = (state_q == WrTbit) && bus_rsp_i.done;
    rx_cmd_o.ccc_done  = (state_q == RxCcc) && bus_rsp_i.done;
    rx_cmd_o.virt      = virt_q;
  end

  assign nack_o = nack_q;

  always_comb begin
    status_o.idle         = (state_q == Idle);
    status_o.transmitting = state_q inside {AckAddr, RdData, RdTbit};
    status_o.xfer_active  = xfer_q;
    status_o.virt_sel     = virt_q;
  end

endmodule

/* i3c_rx_result.sv */
`timescale 1ns/1ps
/*
  I3C RX result path
  Checks write-data parity and pushes good bytes and CCC codes into
  their output stages, flagging parity errors and overflow
*/
module i3c_rx_result
  import i3c_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  rx_cmd_t  rx_cmd_i,
  input  byte_t    bus_data_i,
  input  logic     rx_full_i,
  input  logic     ccc_full_i,
  output logic     rx_push_o,
  output rx_word_t rx_word_o,
  output logic     ccc_push_o,
  output ccc_t     ccc_o,
  output logic     parity_err_o,
  output logic     overflow_o
);

  byte_t data_q;
  // A data byte is waiting for its T-bit
  logic  byte_vld_q;
  logic  tbit_ok;
  logic  tbit_evt;

  always_ff @(posedge clk_i) begin
    if (rx_cmd_i.byte_done) data_q <= bus_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_vld_q <= 1'b0;
    end else if (rx_cmd_i.byte_done) begin
      byte_vld_q <= 1'b1;
    end else if (rx_cmd_i.tbit_done) begin
      byte_vld_q <= 1'b0;
    end
  end

  // Odd parity, T-bit makes the nine bits odd
  assign tbit_ok  = (bus_data_i[0] == ~(^data_q));
  assign tbit_evt = rx_cmd_i.tbit_done && byte_vld_q;

  assign rx_push_o    = tbit_evt && tbit_ok;
  assign parity_err_o = tbit_evt && !tbit_ok;

  always_comb begin
    rx_word_o.data = data_q;
    rx_word_o.virt = rx_cmd_i.virt;
  end

  // Command code is taken directly from the completing byte
  assign ccc_push_o = rx_cmd_i.ccc_done;
  assign ccc_o      = bus_data_i;

  // Stage refuses the push and keeps what it holds
  assign overflow_o = (rx_push_o && rx_full_i) || (ccc_push_o && ccc_full_i);

endmodule

/* i3c_target_top.sv */
`timescale 1ns/1ps
/*
  I3C target sequencing core
  Address decode, transfer sequencer, RX result path and two output
  stages for received bytes and broadcast CCC codes
*/
module i3c_target_top
  import i3c_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_i,
  input  addr_cfg_t own_cfg_i,
  input  addr_cfg_t virt_cfg_i,
  input  bus_rsp_t  bus_rsp_i,
  output bus_req_t  bus_req_o,
  input  logic      tx_valid_i,
  input  tx_word_t  tx_word_i,
  output logic      tx_ready_o,
  output logic      rx_valid_o,
  output rx_word_t  rx_word_o,
  input  logic      rx_ready_i,
  output logic      ccc_valid_o,
  output ccc_t      ccc_o,
  input  logic      ccc_ready_i,
  output logic      nack_o,
  output logic      parity_err_o,
  output logic      overflow_o,
  output status_t   status_o
);

  match_t   match;
  logic     capture;
  logic     clear;
  rx_cmd_t  rx_cmd;
  logic     rx_full;
  logic     ccc_full;
  logic     rx_push;
  rx_word_t rx_word;
  logic     ccc_push;
  ccc_t     ccc_code;

  i3c_addr_decode i3c_addr_decode_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .capture_i  (capture),
    .byte_i     (bus_rsp_i.data),
    .clear_i    (clear),
    .own_cfg_i  (own_cfg_i),
    .virt_cfg_i (virt_cfg_i),
    .match_o    (match)
  );

  i3c_target_seq i3c_target_seq_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .enable_i   (enable_i),
    .bus_rsp_i  (bus_rsp_i),
    .bus_req_o  (bus_req_o),
    .match_i    (match),
    .capture_o  (capture),
    .clear_o    (clear),
    .tx_valid_i (tx_valid_i),
    .tx_word_i  (tx_word_i),
    .tx_ready_o (tx_ready_o),
    .rx_cmd_o   (rx_cmd),
    .nack_o     (nack_o),
    .status_o   (status_o)
  );

  i3c_rx_result i3c_rx_result_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_cmd_i     (rx_cmd),
    .bus_data_i   (bus_rsp_i.data),
    .rx_full_i    (rx_full),
    .ccc_full_i   (ccc_full),
    .rx_push_o    (rx_push),
    .rx_word_o    (rx_word),
    .ccc_push_o   (ccc_push),
    .ccc_o        (ccc_code),
    .parity_err_o (parity_err_o),
    .overflow_o   (overflow_o)
  );

  // Received write bytes
  i3c_out_stage #(.payload_t(rx_word_t)) rx_stage_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_push),
    .data_i  (rx_word),
    .full_o  (rx_full),
    .valid_o (rx_valid_o),
    .data_o  (rx_word_o),
    .ready_i (rx_ready_i)
  );

  // Broadcast command codes
  i3c_out_stage #(.payload_t(ccc_t)) ccc_stage_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (ccc_push),
    .data_i  (ccc_code),
    .full_o  (ccc_full),
    .valid_o (ccc_valid_o),
    .data_o  (ccc_o),
    .ready_i (ccc_ready_i)
  );

endmodule

/* i3c_target_assert.sv */
`timescale 1ns/1ps
/*
  Bus request and handshake assertions for the transfer sequencer
*/
module i3c_target_assert
  import i3c_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input bus_req_t bus_req_i,
  input bus_rsp_t bus_rsp_i,
  input logic     tx_valid_i,
  input logic     tx_ready_i,
  input logic     nack_i
);

  logic [3:0] req_bits;
  assign req_bits = {bus_req_i.rx_byte, bus_req_i.rx_bit, bus_req_i.tx_byte, bus_req_i.tx_bit};

  a_one_req: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(req_bits))
    else $error("more than one bus request");

  // START and STOP may cut a request short
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|req_bits && !bus_rsp_i.done && !bus_rsp_i.start && !bus_rsp_i.stop)
      |=> (bus_req_i == $past(bus_req_i)))
    else $error("bus request changed before done");

  a_tx_ready: assert property (@(posedge clk_i) disable iff (!rst_ni) tx_ready_i |-> tx_valid_i)
    else $error("tx ready without valid");

  a_nack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) nack_i |=> !nack_i)
    else $error("nack longer than one cycle");

endmodule

bind i3c_target_seq i3c_target_assert i3c_target_assert_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .bus_req_i  (bus_req_o),
  .bus_rsp_i  (bus_rsp_i),
  .tx_valid_i (tx_valid_i),
  .tx_ready_i (tx_ready_o),
  .nack_i     (nack_o)
);

/* tb_i3c_target.sv */
`timescale 1ns/1ps
/*
  Testbench for the I3C target core
  Bus layer model replaying a transaction table, TX queue model and scoreboard
*/
module tb_i3c_target
  import i3c_pkg::*;
();

  // One bus transaction, data and TX words are indexed from entry 0
  typedef struct packed {
    byte_t                addr;
    logic [2:0]           ndata;
    logic [3:0][7:0]      data;
    logic [3:0]           bad;
    logic [1:0]           ntx;
    tx_word_t [2:0]       tx;
    logic                 stall;
    logic                 ack;
  } txn_t;

  localparam int NumTxn = 9;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      enable_i;
  addr_cfg_t own_cfg;
  addr_cfg_t virt_cfg;
  bus_rsp_t  bus_rsp;
  bus_req_t  bus_req;
  logic      tx_valid = 1'b0;
  tx_word_t  tx_word = '0;
  logic      tx_ready;
  logic      rx_valid;
  rx_word_t  rx_word;
  logic      rx_ready;
  logic      ccc_valid;
  ccc_t      ccc_code;
  logic      ccc_ready;
  logic      nack;
  logic      parity_err;
  logic      overflow;
  status_t   status;

  txn_t      tab [NumTxn];
  tx_word_t  tx_fifo[$];
  rx_word_t  exp_rx[$];
  ccc_t      exp_ccc[$];
  logic      pop_req;
  int        seed = 28;
  int        mismatches = 0;
  int        failures = 0;
  int        nack_cnt = 0;
  int        perr_cnt = 0;
  int        ovf_cnt = 0;
  int        exp_nack = 0;
  int        exp_perr = 0;
  int        exp_ovf = 0;

  i3c_target_top i3c_target_top_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .enable_i(enable_i),
    .own_cfg_i(own_cfg), .virt_cfg_i(virt_cfg),
    .bus_rsp_i(bus_rsp), .bus_req_o(bus_req),
    .tx_valid_i(tx_valid), .tx_word_i(tx_word), .tx_ready_o(tx_ready),
    .rx_valid_o(rx_valid), .rx_word_o(rx_word), .rx_ready_i(rx_ready),
    .ccc_valid_o(ccc_valid), .ccc_o(ccc_code), .ccc_ready_i(ccc_ready),
    .nack_o(nack), .parity_err_o(parity_err), .overflow_o(overflow),
    .status_o(status)
  );

  always #4 clk_i = ~clk_i;

  // TX queue model, pops what the DUT accepted at the coming edge
  always begin
    @(negedge clk_i);
    pop_req = tx_ready && tx_valid;
    @(posedge clk_i);
    #1;
    if (pop_req) void'(tx_fifo.pop_front());
    tx_valid = (tx_fifo.size() > 0);
    tx_word  = (tx_fifo.size() > 0) ? tx_fifo[0] : '0;
  end

  // Scoreboard, outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (nack) nack_cnt++;
      if (parity_err) perr_cnt++;
      if (overflow) ovf_cnt++;
      if (rx_valid) begin
        if (exp_rx.size() == 0) begin
          failures++;
          $display("unexpected word on the RX output");
        end else begin
          if (rx_word !== exp_rx[0]) begin
            mismatches++;
            $display("mismatch rx_word_o: got %h expected %h", rx_word, exp_rx[0]);
          end
          if (rx_ready) void'(exp_rx.pop_front());
        end
      end
      if (ccc_valid) begin
        if (exp_ccc.size() == 0) begin
          failures++;
          $display("unexpected code on the CCC output");
        end else begin
          if (ccc_code !== exp_ccc[0]) begin
            mismatches++;
            $display("mismatch ccc_o: got %h expected %h", ccc_code, exp_ccc[0]);
          end
          if (ccc_ready) void'(exp_ccc.pop_front());
        end
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    repeat (NumTxn * 400) @(posedge clk_i);
    $display("timeout, the bus model waited too long for a request");
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic txn_t mk(input byte_t addr, input int ndata, input logic [31:0] data,
                              input logic [3:0] bad, input int ntx, input logic [26:0] tx,
                              input logic stall, input logic ack);
    txn_t t;
    t.addr  = addr;
    t.ndata = 3'(ndata);
    t.data  = data;
    t.bad   = bad;
    t.ntx   = 2'(ntx);
    t.tx    = tx;
    t.stall = stall;
    t.ack   = ack;
    return t;
  endfunction

  function automatic logic req_seen(input int kind);
    logic [3:0] f;
    f = {bus_req.rx_byte, bus_req.rx_bit, bus_req.tx_byte, bus_req.tx_bit};
    return f[3 - kind];
  endfunction

  task automatic bus_pulse(input logic is_stop);
    @(posedge clk_i);
    #1;
    if (is_stop) bus_rsp.stop = 1'b1;
    else bus_rsp.start = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rsp.stop  = 1'b0;
    bus_rsp.start = 1'b0;
  endtask

  // 0 rx_byte, 1 rx_bit, 2 tx_byte, 3 tx_bit
  task automatic wait_req(input int kind);
    logic hit;
    hit = 1'b0;
    while (!hit) begin
      @(negedge clk_i);
      hit = req_seen(kind);
    end
  endtask

  // Completes the held request after a random gap
  task automatic respond(input byte_t value);
    int gap;
    gap = 1 + ($random(seed) & 3);
    repeat (gap) @(posedge clk_i);
    #1;
    bus_rsp.done = 1'b1;
    bus_rsp.data = value;
    @(posedge clk_i);
    #1;
    bus_rsp.done = 1'b0;
    bus_rsp.data = '0;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic run_txn(input txn_t t);
    logic     acked;
    logic     tbit;
    logic     more;
    logic     virt_exp;
    logic     stray;
    int       n;
    rx_word_t w;
    @(posedge clk_i);
    #1;
    rx_ready = !t.stall;
    for (n = 0; n < int'(t.ntx); n++) tx_fifo.push_back(t.tx[n]);
    repeat (2) @(posedge clk_i);
    bus_pulse(1'b0);
    wait_req(0);
    respond(t.addr);
    // Virtual device has no dynamic address, so its static one is in effect
    virt_exp = (t.addr != BcastByte) && (t.addr[7:1] == virt_cfg.sta_addr);
    // ACK request or NACK two cycles after the address byte
    repeat (2) @(negedge clk_i);
    acked = bus_req.tx_bit;
    check_val("address ack", 32'(acked), 32'(t.ack));
    check_val("nack_o", 32'(nack), 32'(!t.ack));
    if (!t.ack) exp_nack++;
    if (acked) begin
      check_val("bus_req_o.tx_value", 32'(bus_req.tx_value[0]), 32'(AckValue));
      // Target drives the ACK for an accepted transfer
      check_val("status_o", 32'(status), 32'({3'b011, virt_exp}));
      respond(8'h00);
      if (t.addr == BcastByte) begin
        wait_req(0);
        exp_ccc.push_back(t.data[0]);
        respond(t.data[0]);
        @(negedge clk_i);
        if (!ccc_valid) begin
          failures++;
          $display("no CCC code one cycle after the code byte");
        end
        // Bytes after the code are ignored, so no further bus step is requested
        stray = 1'b0;
        repeat (8) begin
          @(negedge clk_i);
          if (bus_req !== '0) stray = 1'b1;
        end
        if (stray) begin
          failures++;
          $display("bus step requested after the broadcast code");
        end
      end else if (!t.addr[0]) begin
        for (n = 0; n < int'(t.ndata); n++) begin
          wait_req(0);
          respond(t.data[n]);
          wait_req(1);
          // Odd parity over data and T-bit, flipped when corrupted
          tbit = ~(^t.data[n]) ^ t.bad[n];
          w.data = t.data[n];
          w.virt = virt_exp;
          if (t.bad[n]) exp_perr++;
          else if (t.stall && exp_rx.size() > 0) exp_ovf++;
          else exp_rx.push_back(w);
          respond({7'h00, tbit});
          @(negedge clk_i);
          if (!t.bad[n] && !rx_valid) begin
            failures++;
            $display("no RX word one cycle after a good T-bit");
          end
        end
      end else begin
        n = 0;
        more = 1'b1;
        while (more) begin
          wait_req(2);
          check_val("bus_req_o.tx_value", 32'(bus_req.tx_value), 32'(t.tx[n].data));
          respond(8'h00);
          wait_req(3);
          more = !t.tx[n].last && (n + 1 < int'(t.ntx));
          check_val("read T-bit", 32'(bus_req.tx_value[0]), 32'(more));
          respond(8'h00);
          n++;
        end
      end
    end else begin
      // Refused transfer waits without driving or being active
      check_val("status_o", 32'(status[3:1]), 32'h0);
    end
    bus_pulse(1'b1);
    repeat (2) @(posedge clk_i);
    #1;
    rx_ready = 1'b1;
    tx_fifo.delete();
    repeat (4) @(negedge clk_i);
    check_val("status_o", 32'(status), 32'h8);
    if (exp_rx.size() != 0 || exp_ccc.size() != 0) begin
      failures++;
      $display("expected output words were never delivered");
      exp_rx.delete();
      exp_ccc.delete();
    end
    check_val("nack_o pulses", nack_cnt, exp_nack);
    check_val("parity_err_o pulses", perr_cnt, exp_perr);
    check_val("overflow_o pulses", ovf_cnt, exp_ovf);
  endtask

  initial begin
    tab[0] = mk(8'h54, 3, 32'h0033_2211, 4'b0000, 0, '0, 1'b0, 1'b1);
    tab[1] = mk(8'h54, 4, 32'h7766_5544, 4'b0010, 0, '0, 1'b0, 1'b1);
    // Static address hidden by the valid dynamic one
    tab[2] = mk(8'hA0, 2, 32'h0000_BEEF, 4'b0000, 0, '0, 1'b0, 1'b0);
    tab[3] = mk(8'h62, 2, 32'h0000_A55A, 4'b0000, 0, '0, 1'b0, 1'b1);
    tab[4] = mk(8'h55, 0, '0, 4'b0000, 3, {9'h187, 9'h184, 9'h182}, 1'b0, 1'b1);
    tab[5] = mk(8'h55, 0, '0, 4'b0000, 2, {9'h000, 9'h1A4, 9'h1A2}, 1'b0, 1'b1);
    tab[6] = mk(8'h55, 0, '0, 4'b0000, 0, '0, 1'b0, 1'b0);
    tab[7] = mk(BcastByte, 1, 32'h0000_0006, 4'b0000, 0, '0, 1'b0, 1'b1);
    tab[8] = mk(8'h54, 3, 32'h0083_8281, 4'b0000, 0, '0, 1'b1, 1'b1);
    rst_ni    = 1'b0;
    enable_i  = 1'b1;
    own_cfg   = '{sta_addr: 7'h50, sta_valid: 1'b1, dyn_addr: 7'h2A, dyn_valid: 1'b1};
    virt_cfg  = '{sta_addr: 7'h31, sta_valid: 1'b1, dyn_addr: 7'h00, dyn_valid: 1'b0};
    bus_rsp   = '0;
    rx_ready  = 1'b1;
    ccc_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("bus_req_o", 32'(bus_req), 32'h0);
    check_val("ready and valid outputs", 32'({tx_ready, rx_valid, ccc_valid}), 32'h0);
    check_val("pulse outputs", 32'({nack, parity_err, overflow}), 32'h0);
    check_val("status_o", 32'(status), 32'h8);
    for (int k = 0; k < NumTxn; k++) run_txn(tab[k]);
    $display("value mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
i3c_pkg.sv
i3c_out_stage.sv
i3c_addr_decode.sv
i3c_target_seq.sv
i3c_rx_result.sv
i3c_target_top.sv
i3c_target_assert.sv
tb_i3c_target.sv

/* run.sh */
#!/bin/sh
# Build and run the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_i3c_target -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
